//--- verilog/memCmdPkg.sv
package memCmdPkg;

	// ----------------------------------------
	// GPU command word
	// ----------------------------------------
	typedef logic [55:0] gpuCmdT;
	typedef logic [2:0]  gpuCmdCodeT;

	localparam gpuCmdCodeT CMD_NONE       = 3'b000; // Nothing to queue
	localparam gpuCmdCodeT CMD_PIXEL2VRAM = 3'b001;
	localparam gpuCmdCodeT CMD_FILL       = 3'b010;
	localparam gpuCmdCodeT CMD_RDBURST    = 3'b011; // Not supported, dropped
	localparam gpuCmdCodeT CMD_WRBURST    = 3'b100; // Not supported, dropped
	localparam gpuCmdCodeT CMD_VRAM2CPU   = 3'b101;

	// Field LSBs in the 56-bit word
	localparam int CMD_CODE_LSB   = 0;  // [2:0]
	localparam int CMD_SUBADR_LSB = 4;  // [6:4]
	localparam int CMD_ADR_LSB    = 7;  // [21:7]
	localparam int CMD_MASK_LSB   = 22; // [23:22]
	localparam int CMD_PIXEL_LSB  = 24; // [55:24]
	localparam int CMD_COLOR_LSB  = 40; // [55:40]

	// Queue opcodes, bit 0 set means write
	typedef enum logic [2:0] {
		OP_READ_BLOCK  = 3'b000,
		OP_WRITE_BLOCK = 3'b001,
		OP_READ8       = 3'b010,
		OP_WRITE_PAIR  = 3'b011,
		OP_READ_PAIR   = 3'b110
	} queueOpT;

	typedef enum logic [1:0] {RK_TEX_L, RK_TEX_R, RK_CLUT, RK_PAIR} readKindT;
	typedef enum logic [2:0] {ST_IDLE, ST_READ_TEX_L, ST_READ_TEX_R, ST_READ_CLUT, ST_READ_PAIR} arbStateT;

	typedef logic [16:0] texAdrT; // Texture cache line address

	localparam int QUEUE_DEPTH = 4;
	localparam int CLUT_WORDS  = 8; // 32-bit words per CLUT block
endpackage

//--- verilog/ddrBusPkg.sv
package ddrBusPkg;

	// ----------------------------------------
	// DDR side, 32-byte blocks
	// ----------------------------------------
	typedef logic [14:0]  blockAdrT;  // 1 MB as 32768 blocks
	typedef logic [2:0]   subAdrT;    // 4 or 8 byte slot inside a block
	typedef logic [255:0] blockDataT;
	typedef logic [15:0]  byteMaskT;  // One bit per 16-bit pixel

	// Matches the DDR controller size field
	typedef enum logic [1:0] {
		SZ_8BYTE  = 2'd0,
		SZ_32BYTE = 2'd1,
		SZ_4BYTE  = 2'd2
	} accessSizeT;

endpackage

//--- verilog/cmdEncoder.sv
`timescale 1ns/1ps

module cmdEncoder (
	input  logic                 gpuClk,
	input  logic                 i_reset,
	input  memCmdPkg::gpuCmdT    i_memCmd,
	input  logic                 i_texReqL,
	input  logic                 i_texReqR,
	input  memCmdPkg::texAdrT    i_texAdrL,
	input  memCmdPkg::texAdrT    i_texAdrR,
	input  logic                 i_clutReq,
	input  ddrBusPkg::blockAdrT  i_clutAdr,
	input  logic                 i_full,
	input  logic                 i_readDone,
	output logic                 o_push,
	output memCmdPkg::queueOpT   o_op,
	output ddrBusPkg::blockAdrT  o_adr,
	output ddrBusPkg::subAdrT    o_subadr,
	output ddrBusPkg::byteMaskT  o_mask,
	output ddrBusPkg::blockDataT o_data,
	output memCmdPkg::readKindT  o_kind,
	output memCmdPkg::texAdrT    o_texLatchAdr
);
	import memCmdPkg::*;
	import ddrBusPkg::*;

	arbStateT   arbState;
	arbStateT   nextState;
	gpuCmdCodeT cmdCode;
	texAdrT     texAdr;   // Winning texture side
	logic       latchTex;
	logic       isIdle;

	assign cmdCode = i_memCmd[CMD_CODE_LSB +: $bits(gpuCmdCodeT)];
	assign texAdr  = i_texReqL ? i_texAdrL : i_texAdrR; // Left wins
	assign isIdle  = (arbState == ST_IDLE);

	// ----------------------------------------
	// Arbitration and entry packing
	// ----------------------------------------
	always_comb begin
		o_push    = 1'b0;
		o_op      = OP_READ_BLOCK;
		o_adr     = i_memCmd[CMD_ADR_LSB +: $bits(blockAdrT)];
		o_subadr  = '0;
		o_mask    = '0;
		o_data    = '0;
		o_kind    = RK_PAIR;
		latchTex  = 1'b0;
		nextState = i_readDone ? ST_IDLE : arbState; // Back to idle once the read is delivered

		if (cmdCode != CMD_NONE) begin
			// GPU command owns the slot, even if it must wait
			case (cmdCode)
			CMD_PIXEL2VRAM: begin
				o_push   = !i_full;     // Writes never wait for a read
				o_op     = OP_WRITE_PAIR;
				o_subadr = i_memCmd[CMD_SUBADR_LSB +: $bits(subAdrT)];
				o_mask   = {14'd0, i_memCmd[CMD_MASK_LSB +: 2]};
				o_data   = {224'd0, i_memCmd[CMD_PIXEL_LSB +: 32]};
			end
			CMD_FILL: begin
				o_push = !i_full;
				o_op   = OP_WRITE_BLOCK;
				o_mask = '1;                                  // Whole block
				o_data = {16{i_memCmd[CMD_COLOR_LSB +: 16]}}; // Color in every pixel
			end
			CMD_VRAM2CPU: begin
				o_push   = !i_full && isIdle; // One read at a time
				o_op     = OP_READ_PAIR;
				o_subadr = i_memCmd[CMD_SUBADR_LSB +: $bits(subAdrT)];
				o_kind   = RK_PAIR;
				if (!i_full && isIdle) begin
					nextState = ST_READ_PAIR;
				end
			end
			CMD_RDBURST, CMD_WRBURST: begin
				// Burst copy is dropped, nothing queued
			end
			default: begin
			end
			endcase
		end else if (isIdle && !i_full) begin
			if (i_clutReq) begin
				o_push    = 1'b1;
				o_adr     = i_clutAdr;
				o_kind    = RK_CLUT;
				nextState = ST_READ_CLUT;
			end else if (i_texReqL || i_texReqR) begin
				o_push    = 1'b1;
				o_op      = OP_READ8;
				o_adr     = texAdr[16:2];
				o_subadr  = {texAdr[1:0], 1'b0}; // 8-byte slot
				o_kind    = i_texReqL ? RK_TEX_L : RK_TEX_R;
				latchTex  = 1'b1;
				nextState = i_texReqL ? ST_READ_TEX_L : ST_READ_TEX_R;
			end
		end
	end

	always_ff @(posedge gpuClk) begin
		if (i_reset) begin
			arbState <= ST_IDLE;
		end else begin
			arbState <= nextState;
		end
	end

	// Write address for the texture cache when the data returns
	always_ff @(posedge gpuClk) begin
		if (latchTex) begin
			o_texLatchAdr <= texAdr;
		end
	end

endmodule

//--- verilog/cmdQueue.sv
`timescale 1ns/1ps

module cmdQueue (
	input  logic                 gpuClk,
	input  logic                 i_reset,
	input  logic                 i_push,
	input  logic                 i_pop,
	input  memCmdPkg::queueOpT   i_op,
	input  ddrBusPkg::blockAdrT  i_adr,
	input  ddrBusPkg::subAdrT    i_subadr,
	input  ddrBusPkg::byteMaskT  i_mask,
	input  ddrBusPkg::blockDataT i_data,
	input  memCmdPkg::readKindT  i_kind,
	output memCmdPkg::queueOpT   o_op,
	output ddrBusPkg::blockAdrT  o_adr,
	output ddrBusPkg::subAdrT    o_subadr,
	output ddrBusPkg::byteMaskT  o_mask,
	output ddrBusPkg::blockDataT o_data,
	output memCmdPkg::readKindT  o_kind,
	output logic                 o_full,
	output logic                 o_empty
);
	import memCmdPkg::*;
	import ddrBusPkg::*;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0]   ptrT;
	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] cntT;

	queueOpT   opMem   [QUEUE_DEPTH];
	blockAdrT  adrMem  [QUEUE_DEPTH];
	subAdrT    subMem  [QUEUE_DEPTH];
	byteMaskT  maskMem [QUEUE_DEPTH];
	blockDataT dataMem [QUEUE_DEPTH];
	readKindT  kindMem [QUEUE_DEPTH];
	ptrT       wrPtr;
	ptrT       rdPtr;
	cntT       count;   // Entries pending
	logic      doPush;
	logic      doPop;

	assign doPush  = i_push && !o_full;
	assign doPop   = i_pop && !o_empty;
	assign o_full  = (count == cntT'(QUEUE_DEPTH));
	assign o_empty = (count == '0);

	// Head is read straight from storage
	assign o_op     = opMem[rdPtr];
	assign o_adr    = adrMem[rdPtr];
	assign o_subadr = subMem[rdPtr];
	assign o_mask   = maskMem[rdPtr];
	assign o_data   = dataMem[rdPtr];
	assign o_kind   = kindMem[rdPtr];

	always_ff @(posedge gpuClk) begin
		if (doPush) begin
			opMem[wrPtr]   <= i_op;
			adrMem[wrPtr]  <= i_adr;
			subMem[wrPtr]  <= i_subadr;
			maskMem[wrPtr] <= i_mask;
			dataMem[wrPtr] <= i_data;
			kindMem[wrPtr] <= i_kind;
		end
	end

	always_ff @(posedge gpuClk) begin
		if (i_reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == ptrT'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1; // Wrap
			end
			if (doPop) begin
				rdPtr <= (rdPtr == ptrT'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({doPush, doPop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count; // Both or none
			endcase
		end
	end

endmodule

//--- verilog/memIssue.sv
`timescale 1ns/1ps

module memIssue (
	input  logic                   gpuClk,
	input  logic                   i_reset,
	input  memCmdPkg::queueOpT     i_op,
	input  ddrBusPkg::blockAdrT    i_adr,
	input  ddrBusPkg::subAdrT      i_subadr,
	input  ddrBusPkg::byteMaskT    i_mask,
	input  ddrBusPkg::blockDataT   i_data,
	input  memCmdPkg::readKindT    i_kind,
	input  logic                   i_empty,
	input  logic                   i_busy,
	input  ddrBusPkg::blockDataT   i_dataIn,
	input  logic                   i_dataInValid,
	output logic                   o_pop,
	output logic                   o_command,
	output ddrBusPkg::accessSizeT  o_commandSize,
	output logic                   o_write,
	output ddrBusPkg::blockAdrT    o_adr,
	output ddrBusPkg::subAdrT      o_subadr,
	output ddrBusPkg::byteMaskT    o_writeMask,
	output ddrBusPkg::blockDataT   o_dataOut,
	output logic                   o_rdValid,
	output ddrBusPkg::blockDataT   o_rdData,
	output memCmdPkg::readKindT    o_rdKind
);
	import memCmdPkg::*;
	import ddrBusPkg::*;

	logic     issue;
	logic     isWrite;
	logic     waitRead;  // One read in flight
	readKindT pendKind;

	assign isWrite = (i_op == OP_WRITE_BLOCK) || (i_op == OP_WRITE_PAIR);
	assign issue   = !i_empty && !i_busy && !waitRead; // Head waits under busy
	assign o_pop   = issue;   // Pop on the issue cycle

	// ----------------------------------------
	// DDR command
	// ----------------------------------------
	always_comb begin
		case (i_op)
		OP_READ8:                   o_commandSize = SZ_8BYTE;
		OP_WRITE_PAIR, OP_READ_PAIR: o_commandSize = SZ_4BYTE;
		default:                    o_commandSize = SZ_32BYTE;
		endcase
	end

	assign o_command   = issue;
	assign o_write     = issue && isWrite;
	assign o_adr       = i_adr;
	assign o_subadr    = (o_commandSize == SZ_32BYTE) ? '0 : i_subadr; // Full block, no slot
	assign o_writeMask = i_mask;
	assign o_dataOut   = i_data;

	// Returned data tagged with the kind of the read in flight
	assign o_rdValid = i_dataInValid && waitRead;
	assign o_rdData  = i_dataIn;
	assign o_rdKind  = pendKind;

	always_ff @(posedge gpuClk) begin
		if (i_reset) begin
			waitRead <= 1'b0;
		end else if (issue && !isWrite) begin
			waitRead <= 1'b1;
		end else if (i_dataInValid) begin
			waitRead <= 1'b0; // Data back, next issue allowed
		end
	end

	always_ff @(posedge gpuClk) begin
		if (issue && !isWrite) begin
			pendKind <= i_kind;
		end
	end

endmodule

//--- verilog/readRouter.sv
`timescale 1ns/1ps

module readRouter (
	input  logic                 gpuClk,
	input  logic                 i_reset,
	input  logic                 i_rdValid,
	input  ddrBusPkg::blockDataT i_rdData,
	input  memCmdPkg::readKindT  i_rdKind,
	input  memCmdPkg::texAdrT    i_texLatchAdr,
	output logic                 o_texDoneL,
	output logic                 o_texDoneR,
	output logic                 o_texWrite,
	output memCmdPkg::texAdrT    o_texWriteAdr,
	output logic [63:0]          o_texData,
	output logic                 o_clutWrite,
	output logic [2:0]           o_clutIndex,
	output logic [31:0]          o_clutData,
	output logic                 o_clutDone,
	output logic                 o_pairValid,
	output logic [31:0]          o_pairValue,
	output logic                 o_readDone
);
	import memCmdPkg::*;
	import ddrBusPkg::*;

	blockDataT dataReg;    // Returned block
	readKindT  kindReg;
	logic      validReg;   // One cycle after the DDR valid
	logic      clutActive;
	logic [2:0] clutIdx;
	logic      clutLast;

	always_ff @(posedge gpuClk) begin
		if (i_rdValid) begin
			dataReg <= i_rdData;
			kindReg <= i_rdKind;
		end
	end

	// ----------------------------------------
	// Delivery control
	// ----------------------------------------
	always_ff @(posedge gpuClk) begin
		if (i_reset) begin
			validReg   <= 1'b0;
			clutActive <= 1'b0;
			clutIdx    <= '0;
		end else begin
			validReg <= i_rdValid;
			if (i_rdValid && (i_rdKind == RK_CLUT)) begin
				clutActive <= 1'b1; // Word 0 goes out next cycle
				clutIdx    <= '0;
			end else if (clutActive) begin
				clutIdx <= clutIdx + 1'b1;
				if (clutLast) begin
					clutActive <= 1'b0;
				end
			end
		end
	end

	assign clutLast = (clutIdx == 3'(CLUT_WORDS - 1));

	// Texture, low 64 bits of the block
	assign o_texWrite    = validReg && ((kindReg == RK_TEX_L) || (kindReg == RK_TEX_R));
	assign o_texDoneL    = validReg && (kindReg == RK_TEX_L);
	assign o_texDoneR    = validReg && (kindReg == RK_TEX_R);
	assign o_texWriteAdr = i_texLatchAdr;
	assign o_texData     = dataReg[63:0];

	// CLUT, one 32-bit slice per cycle
	assign o_clutWrite = clutActive;
	assign o_clutIndex = clutIdx;
	assign o_clutData  = dataReg[clutIdx * 32 +: 32];
	assign o_clutDone  = clutActive && clutLast;

	assign o_pairValid = validReg && (kindReg == RK_PAIR);
	assign o_pairValue = dataReg[31:0];

	// Releases the encoder FSM
	assign o_readDone = (validReg && (kindReg != RK_CLUT)) || o_clutDone;

endmodule

//--- verilog/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
	input  logic                  gpuClk,
	input  logic                  i_reset,
	input  memCmdPkg::gpuCmdT     i_memCmd,
	output logic                  o_fifoFull,
	output logic                  o_queueEmpty,
	input  logic                  i_texReqL,
	input  logic                  i_texReqR,
	input  memCmdPkg::texAdrT     i_texAdrL,
	input  memCmdPkg::texAdrT     i_texAdrR,
	output logic                  o_texDoneL,
	output logic                  o_texDoneR,
	output logic                  o_texWrite,
	output memCmdPkg::texAdrT     o_texWriteAdr,
	output logic [63:0]           o_texData,
	input  logic                  i_clutReq,
	input  ddrBusPkg::blockAdrT   i_clutAdr,
	output logic                  o_clutWrite,
	output logic [2:0]            o_clutIndex,
	output logic [31:0]           o_clutData,
	output logic                  o_clutDone,
	output logic                  o_pairValid,
	output logic [31:0]           o_pairValue,
	output logic                  o_command,
	input  logic                  i_busy,
	output ddrBusPkg::accessSizeT o_commandSize,
	output logic                  o_write,
	output ddrBusPkg::blockAdrT   o_adr,
	output ddrBusPkg::subAdrT     o_subadr,
	output ddrBusPkg::byteMaskT   o_writeMask,
	output ddrBusPkg::blockDataT  o_dataOut,
	input  ddrBusPkg::blockDataT  i_dataIn,
	input  logic                  i_dataInValid
);
	import memCmdPkg::*;
	import ddrBusPkg::*;

	// Encoder to queue
	logic      push;
	queueOpT   encOp;
	blockAdrT  encAdr;
	subAdrT    encSub;
	byteMaskT  encMask;
	blockDataT encData;
	readKindT  encKind;
	texAdrT    texLatchAdr;
	// Queue head to issue
	logic      pop;
	logic      queueFull;
	logic      queueEmpty;
	queueOpT   headOp;
	blockAdrT  headAdr;
	subAdrT    headSub;
	byteMaskT  headMask;
	blockDataT headData;
	readKindT  headKind;
	// Issue to router
	logic      rdValid;
	blockDataT rdData;
	readKindT  rdKind;
	logic      readDone;

	assign o_fifoFull   = queueFull;
	assign o_queueEmpty = queueEmpty;

	cmdEncoder encoder (
		.gpuClk(gpuClk), .i_reset(i_reset), .i_memCmd(i_memCmd),
		.i_texReqL(i_texReqL), .i_texReqR(i_texReqR),
		.i_texAdrL(i_texAdrL), .i_texAdrR(i_texAdrR),
		.i_clutReq(i_clutReq), .i_clutAdr(i_clutAdr),
		.i_full(queueFull), .i_readDone(readDone),
		.o_push(push), .o_op(encOp), .o_adr(encAdr), .o_subadr(encSub),
		.o_mask(encMask), .o_data(encData), .o_kind(encKind),
		.o_texLatchAdr(texLatchAdr)
	);

	cmdQueue queue (
		.gpuClk(gpuClk), .i_reset(i_reset), .i_push(push), .i_pop(pop),
		.i_op(encOp), .i_adr(encAdr), .i_subadr(encSub), .i_mask(encMask),
		.i_data(encData), .i_kind(encKind),
		.o_op(headOp), .o_adr(headAdr), .o_subadr(headSub), .o_mask(headMask),
		.o_data(headData), .o_kind(headKind),
		.o_full(queueFull), .o_empty(queueEmpty)
	);

	memIssue issue (
		.gpuClk(gpuClk), .i_reset(i_reset),
		.i_op(headOp), .i_adr(headAdr), .i_subadr(headSub), .i_mask(headMask),
		.i_data(headData), .i_kind(headKind), .i_empty(queueEmpty),
		.i_busy(i_busy), .i_dataIn(i_dataIn), .i_dataInValid(i_dataInValid),
		.o_pop(pop), .o_command(o_command), .o_commandSize(o_commandSize),
		.o_write(o_write), .o_adr(o_adr), .o_subadr(o_subadr),
		.o_writeMask(o_writeMask), .o_dataOut(o_dataOut),
		.o_rdValid(rdValid), .o_rdData(rdData), .o_rdKind(rdKind)
	);

	readRouter router (
		.gpuClk(gpuClk), .i_reset(i_reset),
		.i_rdValid(rdValid), .i_rdData(rdData), .i_rdKind(rdKind),
		.i_texLatchAdr(texLatchAdr),
		.o_texDoneL(o_texDoneL), .o_texDoneR(o_texDoneR), .o_texWrite(o_texWrite),
		.o_texWriteAdr(o_texWriteAdr), .o_texData(o_texData),
		.o_clutWrite(o_clutWrite), .o_clutIndex(o_clutIndex),
		.o_clutData(o_clutData), .o_clutDone(o_clutDone),
		.o_pairValid(o_pairValid), .o_pairValue(o_pairValue),
		.o_readDone(readDone)
	);

endmodule

//--- sim/tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen (
	output logic gpuClk,
	output logic o_reset
);
	// 8 ns period
	initial begin
		gpuClk = 1'b0;
		forever #4 gpuClk = ~gpuClk;
	end

	initial begin
		o_reset = 1'b1;
		repeat (5) @(posedge gpuClk); // Reset held 5 cycles
		o_reset <= 1'b0;
	end
endmodule

//--- sim/memArbiterTb.sv
`timescale 1ns/1ps

module memArbiterTb;
	localparam int MAX_TESTS = 32;
	localparam int WORDS     = 9;  // Fields per test line

	logic gpuClk, reset;
	logic [55:0] memCmd;
	logic texReqL, texReqR, clutReq;
	logic [16:0] texAdrL, texAdrR;
	logic [14:0] clutAdr;
	logic busy = 1'b0;
	logic [255:0] dataIn = '0;
	logic dataInValid = 1'b0;
	logic fifoFull, queueEmpty, texDoneL, texDoneR, texWrite, clutWrite, clutDone, pairValid;
	logic [16:0] texWriteAdr;
	logic [63:0] texData;
	logic [2:0] clutIndex;
	logic [31:0] clutData, pairValue;
	logic command, write;
	logic [1:0] commandSize;
	logic [14:0] ddrAdr;
	logic [2:0] ddrSub;
	logic [15:0] writeMask;
	logic [255:0] dataOut;

	logic [255:0] tests [0:MAX_TESTS*WORDS-1];
	logic [292:0] capQ [$];             // Seen DDR commands in issue order
	logic [255:0] replyBlock = '0;
	logic forceBusy = 1'b0;
	logic [31:0] lfsr = 32'h8e39_089f;
	logic busyBit;
	int replyWait = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;
	int numTests;

	tbClockGen clockGen (.gpuClk(gpuClk), .o_reset(reset));

	memArbiter dut (
		.gpuClk(gpuClk), .i_reset(reset), .i_memCmd(memCmd),
		.o_fifoFull(fifoFull), .o_queueEmpty(queueEmpty),
		.i_texReqL(texReqL), .i_texReqR(texReqR), .i_texAdrL(texAdrL), .i_texAdrR(texAdrR),
		.o_texDoneL(texDoneL), .o_texDoneR(texDoneR), .o_texWrite(texWrite),
		.o_texWriteAdr(texWriteAdr), .o_texData(texData),
		.i_clutReq(clutReq), .i_clutAdr(clutAdr), .o_clutWrite(clutWrite),
		.o_clutIndex(clutIndex), .o_clutData(clutData), .o_clutDone(clutDone),
		.o_pairValid(pairValid), .o_pairValue(pairValue),
		.o_command(command), .i_busy(busy), .o_commandSize(commandSize), .o_write(write),
		.o_adr(ddrAdr), .o_subadr(ddrSub), .o_writeMask(writeMask), .o_dataOut(dataOut),
		.i_dataIn(dataIn), .i_dataInValid(dataInValid)
	);

	function automatic logic [31:0] stepLfsr(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0); // Galois step to the right
	endfunction

	// Word i of a reply block
	function automatic logic [255:0] expandReply(input logic [31:0] seed);
		logic [255:0] blk;
		blk = '0;
		for (int i = 0; i < 8; i++) begin
			blk[i*32 +: 32] = seed ^ (32'h1111_1111 * 32'(i));
		end
		return blk;
	endfunction

	task automatic checkEq(input logic [255:0] got, input logic [255:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// ----------------------------------------
	// DDR model, busy source and timeout
	// ----------------------------------------
	always @(posedge gpuClk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout, no completion within %0d cycles", cycleLimit);
			$display("Finished with errors");
			$fatal(1);
		end else begin
			busyBit = lfsr[0];          // One bit per cycle
			lfsr = stepLfsr(lfsr);
			busy <= forceBusy | busyBit;
			dataInValid <= 1'b0;
			if (replyWait != 0) begin
				replyWait = replyWait - 1;
				if (replyWait == 0) begin
					dataInValid <= 1'b1;  // Read answered two cycles on
					dataIn      <= replyBlock;
				end
			end
			if (!reset && command) begin
				capQ.push_back({write, commandSize, ddrSub, ddrAdr, writeMask, dataOut});
				if (!write) replyWait = 2;
			end
		end
	end

	// Holds a request until the queue takes it and returns on that edge
	task automatic waitAccept;
		@(negedge gpuClk);
		while (fifoFull) begin
			@(posedge gpuClk);
			@(negedge gpuClk);
		end
		@(posedge gpuClk);
	endtask

	task automatic driveCmd(input logic [55:0] cmd);
		@(posedge gpuClk);
		memCmd <= cmd;
		waitAccept();
		memCmd <= '0;
	endtask

	task automatic driveTex(input logic left, input logic right, input logic [16:0] adr);
		@(posedge gpuClk);
		texReqL <= left;
		texReqR <= right;
		texAdrL <= left ? adr : ~adr;  // Losing side points at another block
		texAdrR <= left ? ~adr : adr;
		waitAccept();
		texReqL <= 1'b0;
		texReqR <= 1'b0;
	endtask

	task automatic driveClut(input logic [14:0] adr);
		@(posedge gpuClk);
		clutReq <= 1'b1;
		clutAdr <= adr;
		waitAccept();
		clutReq <= 1'b0;
	endtask

	task automatic nextDdrCmd(output logic [292:0] c);
		while (capQ.size() == 0) @(negedge gpuClk);
		c = capQ.pop_front();
	endtask

	task automatic checkDdr(input logic [292:0] c, input logic wr, input logic [15:0] adr,
			input logic [3:0] sub, input logic [3:0] size);
		checkEq(256'(c[292]), 256'(wr), "DDR write");
		checkEq(256'(c[291:290]), 256'(size), "DDR size");
		checkEq(256'(c[289:287]), 256'(sub), "DDR sub-address");
		checkEq(256'(c[286:272]), 256'(adr), "DDR block address");
	endtask

	task automatic runTest(input int t);
		logic [3:0] kind;
		logic [55:0] cmd;
		logic [19:0] adr;
		logic [31:0] seed;
		logic [15:0] expAdr, expMask;
		logic [3:0] expSub, expSize;
		logic [31:0] expData;
		logic [255:0] blk;
		logic [292:0] cap;
		kind    = tests[t*WORDS+0][3:0];
		cmd     = tests[t*WORDS+1][55:0];
		adr     = tests[t*WORDS+2][19:0];
		seed    = tests[t*WORDS+3][31:0];
		expAdr  = tests[t*WORDS+4][15:0];
		expSub  = tests[t*WORDS+5][3:0];
		expSize = tests[t*WORDS+6][3:0];
		expMask = tests[t*WORDS+7][15:0];
		expData = tests[t*WORDS+8][31:0];
		blk     = expandReply(seed);
		replyBlock <= blk;
		case (kind)
		4'd1, 4'd2: begin       // Pixel write, fill
			driveCmd(cmd);
			nextDdrCmd(cap);
			checkDdr(cap, 1'b1, expAdr, expSub, expSize);
			checkEq(256'(cap[271:256]), 256'(expMask), "write mask");
			if (kind == 4'd1) checkEq(cap[255:0], 256'(expData), "pixel data");
			else checkEq(cap[255:0], {16{expData[15:0]}}, "fill data");
		end
		4'd3, 4'd4, 4'd5: begin // Texture left, right, both
			driveTex(kind != 4'd4, kind != 4'd3, adr[16:0]);
			nextDdrCmd(cap);
			checkDdr(cap, 1'b0, expAdr, expSub, expSize);
			while (!texWrite) @(negedge gpuClk);
			checkEq(256'(texData), 256'(blk[63:0]), "texture data");
			checkEq(256'(texData[31:0]), 256'(expData), "texture low word");
			checkEq(256'(texWriteAdr), 256'(adr[16:0]), "texture write address");
			checkEq(256'(texDoneL), 256'(kind != 4'd4), "left done");
			checkEq(256'(texDoneR), 256'(kind == 4'd4), "right done");
		end
		4'd6: begin             // CLUT block in eight words
			driveClut(adr[14:0]);
			nextDdrCmd(cap);
			checkDdr(cap, 1'b0, expAdr, expSub, expSize);
			while (!clutWrite) @(negedge gpuClk);
			for (int i = 0; i < 8; i++) begin
				checkEq(256'(clutWrite), 256'(1), "CLUT write");
				checkEq(256'(clutIndex), 256'(i), "CLUT index");
				checkEq(256'(clutData), 256'(blk[i*32 +: 32]), "CLUT word");
				checkEq(256'(clutDone), 256'(i == 7), "CLUT done");
				@(negedge gpuClk);
			end
			checkEq(256'(clutWrite), 256'(0), "CLUT write after last word");
		end
		4'd7: begin             // Read pair
			driveCmd(cmd);
			nextDdrCmd(cap);
			checkDdr(cap, 1'b0, expAdr, expSub, expSize);
			while (!pairValid) @(negedge gpuClk);
			checkEq(256'(pairValue), 256'(expData), "pair value");
		end
		4'd8: begin             // Write burst against a busy DDR
			@(posedge gpuClk);
			forceBusy <= 1'b1;
			@(posedge gpuClk);
			for (int k = 0; k < 4; k++) driveCmd(cmd + (56'(k) << 24) + (56'(k) << 7));
			@(negedge gpuClk);
			checkEq(256'(fifoFull), 256'(1), "queue full");
			checkEq(256'(queueEmpty), 256'(0), "queue empty while full");
			checkEq(256'(capQ.size()), 256'(0), "commands issued under busy");
			@(posedge gpuClk);
			forceBusy <= 1'b0;
			for (int k = 4; k < 6; k++) driveCmd(cmd + (56'(k) << 24) + (56'(k) << 7));
			for (int k = 0; k < 6; k++) begin
				nextDdrCmd(cap);
				checkDdr(cap, 1'b1, expAdr + 16'(k), expSub, expSize);
				checkEq(256'(cap[271:256]), 256'(expMask), "burst mask");
				checkEq(cap[255:0], 256'(expData + 32'(k)), "burst data in push order");
			end
			@(negedge gpuClk);
			checkEq(256'(queueEmpty), 256'(1), "queue empty after burst");
		end
		default: begin
			$display("Unknown test kind %0d on line %0d", kind, t);
			$display("Finished with errors");
			$fatal(1);
		end
		endcase
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		memCmd  = '0;
		texReqL = 1'b0;
		texReqR = 1'b0;
		texAdrL = '0;
		texAdrR = '0;
		clutReq = 1'b0;
		clutAdr = '0;
		for (int i = 0; i < MAX_TESTS*WORDS; i++) tests[i] = '0;
		$readmemh("sim/memArbiterTests.mem", tests);
		numTests = 0;
		while (numTests < MAX_TESTS && tests[numTests*WORDS] != '0) numTests++;
		cycleLimit = 200 * numTests;
		do @(negedge gpuClk); while (reset);
		for (int t = 0; t < numTests; t++) runTest(t);
		if (numTests == 0) begin
			$display("No tests read from sim/memArbiterTests.mem");
			$display("Finished with errors");
			$fatal(1);
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end
endmodule

//--- sim/memArbiterTests.mem
// kind cmdWord texOrClutAdr replySeed expAdr expSub expSize expMask expData
// kind 1 pixel, 2 fill, 3 texL, 4 texR, 5 both tex, 6 CLUT, 7 read pair, 8 write burst
1 12345678C000A1 00000 00000000 0001 2 2 0003 12345678
1 DEADBEEF891A51 00000 00000000 1234 5 2 0002 DEADBEEF
1 CAFEF00D7FFFF1 00000 00000000 7FFF 7 2 0001 CAFEF00D
2 ABCD0000002132 00000 00000000 0042 0 1 FFFF 0000ABCD
2 13570000300002 00000 00000000 6000 0 1 FFFF 00001357
3 0 12345 A5A50F0F 48D1 2 0 0000 A5A50F0F
4 0 00003 01234567 0000 6 0 0000 01234567
4 0 1FFFE 89ABCDEF 7FFF 4 0 0000 89ABCDEF
3 0 0ABCF 0F1E2D3C 2AF3 6 0 0000 0F1E2D3C
5 0 00105 55AA33CC 0041 2 0 0000 55AA33CC
6 0 00123 76543210 0123 0 1 0000 76543210
6 0 07ABC FEDCBA98 7ABC 0 1 0000 FEDCBA98
7 00000000000835 00000 13579BDF 0010 3 2 0000 13579BDF
7 000000001FFFE5 00000 2468ACE0 3FFF 6 2 0000 2468ACE0
// Bursts step address and pixel by one per write
8 11110000C08011 00000 00000000 0100 1 2 0003 11110000
8 0000FFFE3FF801 00000 00000000 7FF0 0 2 0000 0000FFFE
// Pixel write after the bursts
1 12345678C000A1 00000 00000000 0001 2 2 0003 12345678

//--- memArbiter.f
verilog/memCmdPkg.sv
verilog/ddrBusPkg.sv
verilog/cmdEncoder.sv
verilog/cmdQueue.sv
verilog/memIssue.sv
verilog/readRouter.sv
verilog/memArbiter.sv
sim/tbClockGen.sv
sim/memArbiterTb.sv

//--- runSim.sh
#!/bin/sh
# Build the memArbiter testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module memArbiterTb -f memArbiter.f -o memArbiterSim &&
./obj_dir/memArbiterSim || exit 1
